// File: source/axil_pkg.sv
`default_nettype none

package axil_pkg;

    // Bus widths
    localparam int ADDR_W = 4;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    typedef logic [ADDR_W-1:0] axil_addr_t;
    typedef logic [DATA_W-1:0] axil_data_t;
    typedef logic [STRB_W-1:0] axil_strb_t;
    typedef logic [1:0]        axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    // ========================================
    // Register map

    localparam axil_addr_t REG_CTRL   = 4'h0;
    localparam axil_addr_t REG_SAMPLE = 4'h4;
    localparam axil_addr_t REG_RESULT = 4'h8;
    localparam axil_addr_t REG_STATUS = 4'hC;

    // Field positions inside CTRL and STATUS
    localparam int CTRL_MODE_BIT      = 0;
    localparam int CTRL_CLEAR_BIT     = 1;
    localparam int STATUS_FILLED_BIT  = 8;
    localparam int STATUS_OVF_BIT     = 9;

    // ========================================
    // Channel bundles

    typedef struct packed {
        logic       awvalid;
        axil_addr_t awaddr;
        logic       wvalid;
        axil_data_t wdata;
        axil_strb_t wstrb;
        logic       bready;
    } axil_wreq_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        axil_resp_t bresp;
    } axil_wrsp_t;

    typedef struct packed {
        logic       arvalid;
        axil_addr_t araddr;
        logic       rready;
    } axil_rreq_t;

    typedef struct packed {
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        axil_resp_t rresp;
    } axil_rrsp_t;

endpackage

`default_nettype wire

// File: source/filt_pkg.sv
`default_nettype none

package filt_pkg;

    // Data widths of the filter path
    localparam int SAMPLE_W = 16;
    localparam int RESULT_W = 16;

    // Input sample as written by software
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // Averaged output, same range as the input
    typedef logic signed [RESULT_W-1:0] result_t;

    // Division rounding applied to the window sum
    // TRUNC gives floor, NEAREST gives round half up
    typedef enum logic {
        ROUND_TRUNC   = 1'b0,
        ROUND_NEAREST = 1'b1
    } round_mode_e;

endpackage

`default_nettype wire

// File: source/axil_regs.sv
`timescale 1ns/1ps
`default_nettype none

module axil_regs (
    input  wire                      clk,
    input  wire                      rst,
    input  wire axil_pkg::axil_wreq_t wreq,
    output axil_pkg::axil_wrsp_t     wrsp,
    input  wire axil_pkg::axil_rreq_t rreq,
    output axil_pkg::axil_rrsp_t     rrsp,
    output logic                     sample_valid,
    output filt_pkg::sample_t        sample,
    output filt_pkg::round_mode_e    round_mode,
    output logic                     clear,
    output logic                     pop,
    input  wire filt_pkg::result_t   head,
    input  wire [3:0]                level,
    input  wire                      filled,
    input  wire                      overflow
);

    typedef enum logic {W_IDLE, W_RESP} wr_state_e;
    typedef enum logic {R_IDLE, R_RESP} rd_state_e;

    wr_state_e             wr_state;
    rd_state_e             rd_state;
    filt_pkg::round_mode_e mode_q;
    axil_pkg::axil_resp_t  bresp_q;
    axil_pkg::axil_resp_t  rresp_q;
    axil_pkg::axil_data_t  rdata_q;
    axil_pkg::axil_resp_t  wr_resp_nxt;
    axil_pkg::axil_resp_t  rd_resp_nxt;
    axil_pkg::axil_data_t  rd_data_nxt;
    logic                  wr_accept;
    logic                  rd_accept;
    logic                  ctrl_write;
    logic                  fifo_empty;

    // Address and data are taken together, one write at a time
    assign wr_accept  = (wr_state == W_IDLE) && wreq.awvalid && wreq.wvalid;
    assign rd_accept  = (rd_state == R_IDLE) && rreq.arvalid;
    assign ctrl_write = wr_accept && (wreq.awaddr == axil_pkg::REG_CTRL) && wreq.wstrb[0];
    assign fifo_empty = (level == 4'd0);

    // ========================================
    // Strobes towards core and FIFO

    assign sample_valid = wr_accept && (wreq.awaddr == axil_pkg::REG_SAMPLE);
    assign sample       = filt_pkg::sample_t'(wreq.wdata[filt_pkg::SAMPLE_W-1:0]);
    assign clear        = ctrl_write && wreq.wdata[axil_pkg::CTRL_CLEAR_BIT];
    assign round_mode   = mode_q;
    assign pop          = rd_accept && (rreq.araddr == axil_pkg::REG_RESULT) && !fifo_empty;

    // Only CTRL and SAMPLE take writes
    assign wr_resp_nxt = ((wreq.awaddr == axil_pkg::REG_CTRL) ||
                          (wreq.awaddr == axil_pkg::REG_SAMPLE)) ?
                         axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;

    // ========================================
    // Write channel

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= W_IDLE;
            mode_q   <= filt_pkg::ROUND_TRUNC;
        end else begin
            case (wr_state)
                W_IDLE: begin
                    if (wr_accept) begin
                        wr_state <= W_RESP;
                    end
                end
                W_RESP: begin
                    if (wreq.bready) begin
                        wr_state <= W_IDLE;
                    end
                end
                default: wr_state <= W_IDLE;
            endcase
            if (ctrl_write) begin
                mode_q <= filt_pkg::round_mode_e'(wreq.wdata[axil_pkg::CTRL_MODE_BIT]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bresp_q <= wr_resp_nxt;
        end
    end

    // ========================================
    // Read channel

    always_comb begin
        rd_data_nxt = '0;
        rd_resp_nxt = axil_pkg::RESP_OKAY;
        case (rreq.araddr)
            axil_pkg::REG_CTRL: begin
                rd_data_nxt[axil_pkg::CTRL_MODE_BIT] = mode_q;
            end
            axil_pkg::REG_RESULT: begin
                if (fifo_empty) begin
                    rd_resp_nxt = axil_pkg::RESP_SLVERR;
                end else begin
                    rd_data_nxt = {
                        {(axil_pkg::DATA_W - filt_pkg::RESULT_W){head[filt_pkg::RESULT_W-1]}},
                        head
                    };
                end
            end
            axil_pkg::REG_STATUS: begin
                rd_data_nxt[3:0]                        = level;
                rd_data_nxt[axil_pkg::STATUS_FILLED_BIT] = filled;
                rd_data_nxt[axil_pkg::STATUS_OVF_BIT]    = overflow;
            end
            // SAMPLE is write only, the rest is unmapped
            default: rd_resp_nxt = axil_pkg::RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= R_IDLE;
        end else begin
            case (rd_state)
                R_IDLE: begin
                    if (rd_accept) begin
                        rd_state <= R_RESP;
                    end
                end
                R_RESP: begin
                    if (rreq.rready) begin
                        rd_state <= R_IDLE;
                    end
                end
                default: rd_state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata_q <= rd_data_nxt;
            rresp_q <= rd_resp_nxt;
        end
    end

    // Response bundles
    always_comb begin
        wrsp.awready = wr_accept;
        wrsp.wready  = wr_accept;
        wrsp.bvalid  = (wr_state == W_RESP);
        wrsp.bresp   = bresp_q;
        rrsp.arready = rd_accept;
        rrsp.rvalid  = (rd_state == R_RESP);
        rrsp.rdata   = rdata_q;
        rrsp.rresp   = rresp_q;
    end

endmodule

`default_nettype wire

// File: source/window_ram.sv
`timescale 1ns/1ps
`default_nettype none

module window_ram #(
    parameter int WINDOW_LEN = 8
) (
    input  wire                          clk,
    input  wire                          we,
    input  wire [$clog2(WINDOW_LEN)-1:0] addr,
    input  wire filt_pkg::sample_t       wdata,
    output filt_pkg::sample_t            rdata
);

    // One entry per window position
    filt_pkg::sample_t mem [WINDOW_LEN];

    // ========================================
    // Read before write on the same address

    // The old entry leaves as the new sample goes in,
    // so rdata trails the input by exactly one window
    always_ff @(posedge clk) begin
        if (we) begin
            rdata     <= mem[addr];
            mem[addr] <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: source/moving_average.sv
`timescale 1ns/1ps
`default_nettype none

module moving_average #(
    parameter int WINDOW_LEN = 8
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         clear,
    input  wire                         sample_valid,
    input  wire filt_pkg::sample_t      sample,
    input  wire filt_pkg::round_mode_e  round_mode,
    output logic                        result_valid,
    output filt_pkg::result_t           result,
    output logic                        filled
);

    localparam int LOG2_LEN = $clog2(WINDOW_LEN);
    // Window sum plus one bit of headroom for the rounding offset
    localparam int ACC_W    = filt_pkg::SAMPLE_W + LOG2_LEN + 1;

    typedef logic [LOG2_LEN-1:0]                ptr_t;
    typedef logic [LOG2_LEN:0]                  count_t;
    typedef logic signed [filt_pkg::SAMPLE_W:0] diff_t;
    typedef logic signed [ACC_W-1:0]            acc_t;

    localparam acc_t   HALF = acc_t'(WINDOW_LEN / 2);
    localparam count_t FULL = count_t'(WINDOW_LEN);

    ptr_t              wr_ptr;
    count_t            fill_cnt;
    filt_pkg::sample_t ram_rdata;
    filt_pkg::sample_t old_sample;
    logic              s1_valid;
    logic              s1_use_old;
    filt_pkg::sample_t s1_sample;
    logic              s2_valid;
    diff_t             s2_diff;
    acc_t              acc;
    acc_t              acc_sum;
    acc_t              acc_rnd;
    acc_t              acc_avg;

    assign filled = (fill_cnt == FULL);

    // Comb delay line
    window_ram #(
        .WINDOW_LEN (WINDOW_LEN)
    ) window_ram_i (
        .clk   (clk),
        .we    (sample_valid),
        .addr  (wr_ptr),
        .wdata (sample),
        .rdata (ram_rdata)
    );

    // Until the window has filled the RAM holds stale data
    assign old_sample = s1_use_old ? ram_rdata : '0;

    // Integrator and scaling
    assign acc_sum = acc + acc_t'(s2_diff);
    assign acc_rnd = (round_mode == filt_pkg::ROUND_NEAREST) ? acc_sum + HALF : acc_sum;
    assign acc_avg = acc_rnd >>> LOG2_LEN;

    // ========================================
    // Control and integrator state

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            wr_ptr       <= '0;
            fill_cnt     <= '0;
            s1_valid     <= 1'b0;
            s2_valid     <= 1'b0;
            result_valid <= 1'b0;
            acc          <= '0;
        end else begin
            s1_valid     <= sample_valid;
            s2_valid     <= s1_valid;
            result_valid <= s2_valid;
            if (sample_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
                if (!filled) begin
                    fill_cnt <= fill_cnt + 1'b1;
                end
            end
            if (s2_valid) begin
                acc <= acc_sum;
            end
        end
    end

    // ========================================
    // Pipeline payload

    always_ff @(posedge clk) begin
        if (sample_valid) begin
            s1_sample  <= sample;
            s1_use_old <= filled;
        end
        if (s1_valid) begin
            s2_diff <= diff_t'(s1_sample) - diff_t'(old_sample);
        end
        if (s2_valid) begin
            result <= acc_avg[filt_pkg::RESULT_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: source/result_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module result_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     clear,
    input  wire                     push,
    input  wire filt_pkg::result_t  din,
    input  wire                     pop,
    output filt_pkg::result_t       head,
    output logic [3:0]              level,
    output logic                    overflow
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    typedef logic [PTR_W-1:0] ptr_t;

    localparam ptr_t LAST = ptr_t'(FIFO_DEPTH - 1);

    filt_pkg::result_t mem [FIFO_DEPTH];
    ptr_t              wr_ptr;
    ptr_t              rd_ptr;
    logic [3:0]        count;
    logic              full;
    logic              do_push;
    logic              do_pop;

    assign full    = (count == 4'(FIFO_DEPTH));
    assign do_pop  = pop && (count != 4'd0);
    // A pop frees a slot for a push in the same cycle
    assign do_push = push && (!full || do_pop);
    assign head    = mem[rd_ptr];
    assign level   = count;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 4'd1;
            end else if (do_pop && !do_push) begin
                count <= count - 4'd1;
            end
            // Sticky until clear
            if (push && !do_push) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

`default_nettype wire

// File: source/avg_filter_top.sv
`timescale 1ns/1ps
`default_nettype none

module avg_filter_top #(
    parameter int WINDOW_LEN = 8,
    parameter int FIFO_DEPTH = 8
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire axil_pkg::axil_wreq_t wreq,
    output axil_pkg::axil_wrsp_t      wrsp,
    input  wire axil_pkg::axil_rreq_t rreq,
    output axil_pkg::axil_rrsp_t      rrsp
);

    logic                  sample_valid;
    filt_pkg::sample_t     sample;
    filt_pkg::round_mode_e round_mode;
    logic                  clear;
    logic                  result_valid;
    filt_pkg::result_t     result;
    logic                  filled;
    logic                  pop;
    filt_pkg::result_t     head;
    logic [3:0]            level;
    logic                  overflow;

    // ========================================
    // Bus side register block

    axil_regs axil_regs_i (
        .clk          (clk),
        .rst          (rst),
        .wreq         (wreq),
        .wrsp         (wrsp),
        .rreq         (rreq),
        .rrsp         (rrsp),
        .sample_valid (sample_valid),
        .sample       (sample),
        .round_mode   (round_mode),
        .clear        (clear),
        .pop          (pop),
        .head         (head),
        .level        (level),
        .filled       (filled),
        .overflow     (overflow)
    );

    // Averaging core
    moving_average #(
        .WINDOW_LEN (WINDOW_LEN)
    ) moving_average_i (
        .clk          (clk),
        .rst          (rst),
        .clear        (clear),
        .sample_valid (sample_valid),
        .sample       (sample),
        .round_mode   (round_mode),
        .result_valid (result_valid),
        .result       (result),
        .filled       (filled)
    );

    // Results wait here until software reads them
    result_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) result_fifo_i (
        .clk      (clk),
        .rst      (rst),
        .clear    (clear),
        .push     (result_valid),
        .din      (result),
        .pop      (pop),
        .head     (head),
        .level    (level),
        .overflow (overflow)
    );

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    // Free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: tb/avg_filter_chk.sv
`timescale 1ns/1ps
`default_nettype none

module avg_filter_chk (
    input wire                       clk,
    input wire                       rst,
    input wire axil_pkg::axil_wreq_t wreq,
    input wire axil_pkg::axil_wrsp_t wrsp,
    input wire axil_pkg::axil_rreq_t rreq,
    input wire axil_pkg::axil_rrsp_t rrsp
);

    // Count of failed assertions
    int failures;

    initial begin
        failures = 0;
    end

    // ========================================
    // AXI4-Lite response channels

    // Write response holds until the master takes it
    b_hold: assert property (@(posedge clk) disable iff (rst)
        wrsp.bvalid && !wreq.bready |=> wrsp.bvalid && $stable(wrsp.bresp))
        else begin
            $error("bvalid or bresp changed while bready was low");
            failures++;
        end

    // Read data holds until the master takes it
    r_hold: assert property (@(posedge clk) disable iff (rst)
        rrsp.rvalid && !rreq.rready |=>
            rrsp.rvalid && $stable(rrsp.rdata) && $stable(rrsp.rresp))
        else begin
            $error("rvalid, rdata or rresp changed while rready was low");
            failures++;
        end

    // Both channels come out of reset idle
    reset_idle: assert property (@(posedge clk)
        rst |=> !wrsp.bvalid && !rrsp.rvalid)
        else begin
            $error("Response valid in the cycle after reset");
            failures++;
        end

endmodule

`default_nettype wire

// File: tb/avg_filter_tb.sv
`timescale 1ns/1ps
`default_nettype none

module avg_filter_tb;

    localparam int WINDOW_LEN  = 8;
    localparam int FIFO_DEPTH  = 8;
    localparam int CLK_NS      = 20;
    localparam int MAX_WAIT    = 20;
    // Upper bound on bus transfers over all tests
    localparam int NUM_XFERS   = 300;
    localparam int WATCHDOG_NS = NUM_XFERS * 40 * CLK_NS + 20000;

    logic                 clk;
    logic                 rst;
    axil_pkg::axil_wreq_t wreq;
    axil_pkg::axil_wrsp_t wrsp;
    axil_pkg::axil_rreq_t rreq;
    axil_pkg::axil_rrsp_t rrsp;

    int          value_errors;
    int          protocol_errors;
    int          assertion_errors;
    logic [31:0] lfsr_state;
    int          hist [WINDOW_LEN];
    logic        model_nearest;
    int          exp_q [$];

    tb_clk_gen #(
        .PERIOD_NS (CLK_NS)
    ) tb_clk_gen_i (
        .clk (clk)
    );

    avg_filter_top #(
        .WINDOW_LEN (WINDOW_LEN),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) avg_filter_top_i (
        .clk  (clk),
        .rst  (rst),
        .wreq (wreq),
        .wrsp (wrsp),
        .rreq (rreq),
        .rrsp (rrsp)
    );

    bind axil_regs avg_filter_chk avg_filter_chk_i (
        .clk  (clk),
        .rst  (rst),
        .wreq (wreq),
        .wrsp (wrsp),
        .rreq (rreq),
        .rrsp (rrsp)
    );

    // ========================================
    // Stimulus and reference model

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic int random_sample();
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < 16; i++) begin
            v = {v[14:0], lfsr_bit()};
        end
        return int'($signed(v));
    endfunction

    function automatic int floor_div(input int num, input int den);
        if (num >= 0) begin
            return num / den;
        end
        return -((-num + den - 1) / den);
    endfunction

    function automatic int floor_mod(input int num, input int den);
        return ((num % den) + den) % den;
    endfunction

    // Zeros stand in for samples before the window has filled
    function automatic void model_clear();
        foreach (hist[i]) begin
            hist[i] = 0;
        end
    endfunction

    function automatic int model_push(input int x);
        int sum;
        for (int i = WINDOW_LEN - 1; i > 0; i--) begin
            hist[i] = hist[i-1];
        end
        hist[0] = x;
        sum = 0;
        foreach (hist[i]) begin
            sum += hist[i];
        end
        if (model_nearest) begin
            return floor_div(sum + WINDOW_LEN / 2, WINDOW_LEN);
        end
        return floor_div(sum, WINDOW_LEN);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %s: got 0x%h expected 0x%h", name, got, exp);
            value_errors++;
        end
    endtask

    // ========================================
    // AXI4-Lite single transfers that start and end on a falling edge

    task automatic axil_write(input axil_pkg::axil_addr_t addr, input axil_pkg::axil_data_t data,
                              input int stall, output axil_pkg::axil_resp_t resp);
        int   waited;
        logic taken;
        wreq.awvalid = 1'b1;
        wreq.awaddr  = addr;
        wreq.wvalid  = 1'b1;
        wreq.wdata   = data;
        wreq.wstrb   = 4'hF;
        waited       = 0;
        taken        = 1'b0;
        // Ready flags are looked at just before the edge that takes them
        while (!taken && waited < MAX_WAIT) begin
            @(posedge clk);
            taken = wrsp.awready && wrsp.wready;
            waited++;
        end
        @(negedge clk);
        wreq.awvalid = 1'b0;
        wreq.wvalid  = 1'b0;
        resp         = wrsp.bresp;
        assert (taken) else begin
            $display("Write to offset 0x%h was never accepted", addr);
            protocol_errors++;
        end
        assert (wrsp.bvalid) else begin
            $display("Write to offset 0x%h got no response after the handshake", addr);
            protocol_errors++;
        end
        repeat (stall) begin
            @(negedge clk);
            assert (wrsp.bvalid && wrsp.bresp == resp) else begin
                $display("Write response changed while bready was low");
                protocol_errors++;
            end
        end
        wreq.bready = 1'b1;
        @(negedge clk);
        wreq.bready = 1'b0;
        assert (!wrsp.bvalid) else begin
            $display("Write response still pending after bready");
            protocol_errors++;
        end
    endtask

    task automatic axil_read(input axil_pkg::axil_addr_t addr, input int stall,
                             output axil_pkg::axil_data_t data,
                             output axil_pkg::axil_resp_t resp);
        int   waited;
        logic taken;
        rreq.arvalid = 1'b1;
        rreq.araddr  = addr;
        waited       = 0;
        taken        = 1'b0;
        while (!taken && waited < MAX_WAIT) begin
            @(posedge clk);
            taken = rrsp.arready;
            waited++;
        end
        @(negedge clk);
        rreq.arvalid = 1'b0;
        data         = rrsp.rdata;
        resp         = rrsp.rresp;
        assert (taken) else begin
            $display("Read from offset 0x%h was never accepted", addr);
            protocol_errors++;
        end
        assert (rrsp.rvalid) else begin
            $display("Read from offset 0x%h gave no data after the handshake", addr);
            protocol_errors++;
        end
        repeat (stall) begin
            @(negedge clk);
            assert (rrsp.rvalid && rrsp.rdata == data && rrsp.rresp == resp) else begin
                $display("Read response changed while rready was low");
                protocol_errors++;
            end
        end
        rreq.rready = 1'b1;
        @(negedge clk);
        rreq.rready = 1'b0;
        assert (!rrsp.rvalid) else begin
            $display("Read response still pending after rready");
            protocol_errors++;
        end
    endtask

    task automatic write_ok(input axil_pkg::axil_addr_t addr, input axil_pkg::axil_data_t data,
                            input int stall);
        axil_pkg::axil_resp_t resp;
        axil_write(addr, data, stall, resp);
        check_value("bresp", 32'(resp), 32'(axil_pkg::RESP_OKAY));
    endtask

    task automatic set_mode(input logic nearest);
        write_ok(axil_pkg::REG_CTRL, {31'b0, nearest}, 0);
        model_nearest = nearest;
    endtask

    task automatic send_sample(input int x, input int stall);
        write_ok(axil_pkg::REG_SAMPLE, 32'(x), stall);
        exp_q.push_back(model_push(x));
    endtask

    // Polls STATUS until the masked bits match
    task automatic wait_status(input logic [31:0] mask, input logic [31:0] want,
                               input int stall, output axil_pkg::axil_data_t st);
        int                   polls;
        axil_pkg::axil_resp_t resp;
        polls = 0;
        do begin
            axil_read(axil_pkg::REG_STATUS, stall, st, resp);
            polls++;
        end while (((st & mask) != want) && polls < MAX_WAIT);
        assert ((st & mask) == want) else begin
            $display("STATUS never showed 0x%h under mask 0x%h", want, mask);
            protocol_errors++;
        end
    endtask

    task automatic read_result(input int stall);
        axil_pkg::axil_data_t data;
        axil_pkg::axil_resp_t resp;
        int                   exp;
        axil_read(axil_pkg::REG_RESULT, stall, data, resp);
        check_value("rresp", 32'(resp), 32'(axil_pkg::RESP_OKAY));
        assert (exp_q.size() > 0) else begin
            $display("Result read with no expected value left");
            protocol_errors++;
        end
        if (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            check_value("rdata", data, 32'(exp));
        end
    endtask

    // ========================================
    // Directed tests

    task automatic fill_and_truncate();
        axil_pkg::axil_data_t st;
        for (int i = 0; i < 12; i++) begin
            send_sample(random_sample(), 0);
            wait_status(32'hF, 32'd1, 0, st);
            check_value("filled", 32'(st[axil_pkg::STATUS_FILLED_BIT]),
                        (i >= WINDOW_LEN - 1) ? 32'd1 : 32'd0);
            read_result(0);
        end
    endtask

    task automatic rounding_halves();
        int                   bases [12] = '{-3, 5, -1200, 900, -7, 13, -20000, 19000,
                                             -4, 4, -9, 3};
        int                   rest;
        int                   x;
        axil_pkg::axil_data_t st;
        axil_pkg::axil_resp_t resp;
        set_mode(1'b1);
        for (int i = 0; i < 12; i++) begin
            rest = 0;
            for (int k = 0; k < WINDOW_LEN - 1; k++) begin
                rest += hist[k];
            end
            // Window sum lands on 4 mod 8, an exact half
            x = bases[i] - floor_mod(rest + bases[i] - WINDOW_LEN / 2, WINDOW_LEN);
            send_sample(x, 0);
            wait_status(32'hF, 32'd1, 0, st);
            read_result(0);
        end
        axil_read(axil_pkg::REG_CTRL, 0, st, resp);
        check_value("ctrl", st, 32'd1);
    endtask

    task automatic error_responses();
        axil_pkg::axil_data_t data;
        axil_pkg::axil_resp_t resp;
        axil_read(axil_pkg::REG_RESULT, 0, data, resp);
        check_value("rresp", 32'(resp), 32'(axil_pkg::RESP_SLVERR));
        check_value("rdata", data, 32'd0);
        axil_write(axil_pkg::REG_RESULT, 32'h1234, 0, resp);
        check_value("bresp", 32'(resp), 32'(axil_pkg::RESP_SLVERR));
        axil_write(axil_pkg::REG_STATUS, 32'h1, 0, resp);
        check_value("bresp", 32'(resp), 32'(axil_pkg::RESP_SLVERR));
        axil_read(4'h2, 0, data, resp);
        check_value("rresp", 32'(resp), 32'(axil_pkg::RESP_SLVERR));
        axil_read(axil_pkg::REG_SAMPLE, 0, data, resp);
        check_value("rresp", 32'(resp), 32'(axil_pkg::RESP_SLVERR));
    endtask

    task automatic overflow_drain();
        axil_pkg::axil_data_t st;
        set_mode(1'b0);
        for (int i = 0; i < 10; i++) begin
            send_sample(random_sample(), 0);
        end
        wait_status(32'h200, 32'h200, 0, st);
        check_value("level", 32'(st[3:0]), 32'(FIFO_DEPTH));
        check_value("overflow", 32'(st[axil_pkg::STATUS_OVF_BIT]), 32'd1);
        // The last two results found the FIFO full
        repeat (2) begin
            exp_q.delete(exp_q.size() - 1);
        end
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            read_result(0);
        end
        wait_status(32'hF, 32'd0, 0, st);
    endtask

    task automatic clear_restart();
        axil_pkg::axil_data_t st;
        axil_pkg::axil_resp_t resp;
        for (int i = 0; i < 3; i++) begin
            send_sample(random_sample(), 0);
        end
        // Clear follows at once, so the last sample is still in flight
        write_ok(axil_pkg::REG_CTRL, 32'h3, 0);
        model_nearest = 1'b1;
        model_clear();
        exp_q.delete();
        axil_read(axil_pkg::REG_STATUS, 0, st, resp);
        check_value("status", st & 32'h30F, 32'd0);
        axil_read(axil_pkg::REG_CTRL, 0, st, resp);
        check_value("ctrl", st, 32'd1);
        for (int i = 0; i < 4; i++) begin
            send_sample(random_sample(), 0);
            wait_status(32'hF, 32'd1, 0, st);
            read_result(0);
        end
    endtask

    task automatic back_pressure();
        axil_pkg::axil_data_t st;
        for (int i = 0; i < 5; i++) begin
            send_sample(random_sample(), 4 + i);
            wait_status(32'hF, 32'd1, 3, st);
            read_result(6);
        end
    endtask

    // ========================================
    // Main sequence and watchdog

    initial begin
        value_errors     = 0;
        protocol_errors  = 0;
        assertion_errors = 0;
        lfsr_state       = 32'd99707;
        model_nearest    = 1'b0;
        model_clear();
        rst  = 1'b1;
        wreq = '0;
        rreq = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        fill_and_truncate();
        rounding_halves();
        error_responses();
        overflow_drain();
        clear_restart();
        back_pressure();
        assertion_errors = avg_filter_top_i.axil_regs_i.avg_filter_chk_i.failures;
        $display("Errors: value %0d, protocol %0d, assertion %0d",
                 value_errors, protocol_errors, assertion_errors);
        if (value_errors == 0 && protocol_errors == 0 && assertion_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests completed", WATCHDOG_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
source/axil_pkg.sv
source/filt_pkg.sv
source/axil_regs.sv
source/window_ram.sv
source/moving_average.sv
source/result_fifo.sv
source/avg_filter_top.sv
tb/tb_clk_gen.sv
tb/avg_filter_chk.sv
tb/avg_filter_tb.sv
